// ==== max_pool.f ====
+incdir+.
pool_pkg.sv
pool_win_if.sv
pool_res_if.sv
pool_decode.sv
pool_execute.sv
pool_result.sv
pool_top.sv
tb_pool_top.sv

// ==== pool_decode.sv ====
`include "pool_defs.svh"

module pool_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  pool_pkg::chan_vec_t in_data,
    pool_win_if.dec             win
);

    import pool_pkg::*;

    localparam int ROW_W = $clog2(`POOL_IMG_ROWS);

    //////////////////////////////
    // position counters
    //////////////////////////////

    col_idx_t         col_q;
    logic [ROW_W-1:0] row_q;
    logic             row_end;
    logic             frame_end;

    // last pixel of a row / of the whole frame
    assign row_end   = (col_q == col_idx_t'(`POOL_IMG_COLS - 1));
    assign frame_end = row_end && (row_q == ROW_W'(`POOL_IMG_ROWS - 1));

    // advance only on accepted pixels, gaps hold everything
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_q <= '0;
            row_q <= '0;
        end else if (in_valid) begin
            if (row_end) begin
                col_q <= '0;
            end else begin
                col_q <= col_q + 1'b1;
            end
            // next frame starts right away, no idle cycle
            if (frame_end) begin
                row_q <= '0;
            end else if (row_end) begin
                row_q <= row_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // window phase tagging
    //////////////////////////////

    // even row -> top half of the window
    // odd row, even col -> bottom left
    // odd row, odd col -> bottom right, window done
    always_comb begin
        if (!row_q[0]) begin
            win.phase = PH_TOP;
        end else if (!col_q[0]) begin
            win.phase = PH_BOT_LEFT;
        end else begin
            win.phase = PH_BOT_RIGHT;
        end
    end

    // pixel and column pass straight through, no delay
    assign win.px_valid = in_valid;
    assign win.px_data  = in_data;
    assign win.col      = col_q;

endmodule

// ==== pool_defs.svh ====
`ifndef POOL_DEFS_SVH
`define POOL_DEFS_SVH

//////////////////////////////
// image shape
//////////////////////////////

// pixels per row, must be even
`define POOL_IMG_COLS 8

// rows per frame, must be even
`define POOL_IMG_ROWS 6

//////////////////////////////
// datapath
//////////////////////////////

// unsigned pixel width
`define POOL_DATA_W 16

// channels sharing one pixel stream
`define POOL_CHANNELS 4

`endif

// ==== pool_execute.sv ====
`include "pool_defs.svh"

module pool_execute (
    input  logic    clk,
    pool_win_if.exe win,
    pool_res_if.exe res
);

    import pool_pkg::*;

    //////////////////////////////
    // helpers
    //////////////////////////////

    // unsigned two-way max
    function automatic pixel_t pix_max(input pixel_t a, input pixel_t b);
        pixel_t m;
        m = (a > b) ? a : b;
        return m;
    endfunction

    //////////////////////////////
    // phase decode
    //////////////////////////////

    logic top_wr;
    logic left_upd;
    logic win_done;

    // even rows fill the line buffer
    assign top_wr   = win.px_valid && (win.phase == PH_TOP);

    // bottom left pixel folds into the left-column max
    assign left_upd = win.px_valid && (win.phase == PH_BOT_LEFT);

    // bottom right pixel closes the window
    assign win_done = win.px_valid && (win.phase == PH_BOT_RIGHT);

    assign res.max_valid = win_done;

    //////////////////////////////
    // per-channel datapath
    //////////////////////////////

    for (genvar c = 0; c < `POOL_CHANNELS; c++) begin : g_chan

        // one image row of this channel
        pixel_t line_buf [`POOL_IMG_COLS];

        // max of top-left and bottom-left pixels
        pixel_t left_max;

        // pixel above the incoming one
        pixel_t top_px;

        // incoming pixel of this channel
        pixel_t cur_px;

        // max of the right column of the window
        pixel_t right_max;

        assign cur_px = win.px_data[c];

        // read at the current column, only used on odd rows
        assign top_px = line_buf[win.col];

        // buffer entries are always written on the even row first
        always_ff @(posedge clk) begin
            if (top_wr) begin
                line_buf[win.col] <= cur_px;
            end
        end

        // held across gaps until the right pixel arrives
        always_ff @(posedge clk) begin
            if (left_upd) begin
                left_max <= pix_max(top_px, cur_px);
            end
        end

        assign right_max = pix_max(top_px, cur_px);

        // final compare, sampled by result on win_done
        assign res.max_data[c] = pix_max(left_max, right_max);

    end

endmodule

// ==== pool_pkg.sv ====
`include "pool_defs.svh"

package pool_pkg;

    //////////////////////////////
    // pixel and channel types
    //////////////////////////////

    // one unsigned pixel
    typedef logic [`POOL_DATA_W-1:0] pixel_t;

    // one pixel per channel, channel 0 in the low bits
    typedef pixel_t [`POOL_CHANNELS-1:0] chan_vec_t;

    // column position inside a row
    typedef logic [$clog2(`POOL_IMG_COLS)-1:0] col_idx_t;

    //////////////////////////////
    // window role
    //////////////////////////////

    // where an accepted pixel sits in its 2x2 window
    typedef enum logic [1:0] {
        PH_TOP       = 2'd0,
        PH_BOT_LEFT  = 2'd1,
        PH_BOT_RIGHT = 2'd2
    } pool_phase_e;

endpackage

// ==== pool_res_if.sv ====
interface pool_res_if;

    // one pulse per completed window
    logic                max_valid;

    // window maxima, one per channel
    pool_pkg::chan_vec_t max_data;

    // execute side, drives the compare result
    modport exe (
        output max_valid,
        output max_data
    );

    // result side, registers it
    modport res (
        input max_valid,
        input max_data
    );

endinterface

// ==== pool_result.sv ====
module pool_result (
    input  logic                clk,
    input  logic                rst_n,
    pool_res_if.res             res,
    output logic                out_valid,
    output pool_pkg::chan_vec_t out_data
);

    import pool_pkg::*;

    //////////////////////////////
    // output stage
    //////////////////////////////

    // data to load, zero on cycles with no window
    chan_vec_t next_data;

    always_comb begin
        if (res.max_valid) begin
            next_data = res.max_data;
        end else begin
            next_data = '0;
        end
    end

    // one register stage, so out_valid is a single-cycle pulse
    // one cycle after the bottom right pixel
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
        end else begin
            out_valid <= res.max_valid;
            // data stays zero while out_valid is low
            out_data  <= next_data;
        end
    end

endmodule

// ==== pool_top.sv ====
module pool_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  pool_pkg::chan_vec_t in_data,
    output logic                out_valid,
    output pool_pkg::chan_vec_t out_data
);

    //////////////////////////////
    // stage links
    //////////////////////////////

    // decode -> execute, tagged pixels
    pool_win_if win_bus ();

    // execute -> result, window maxima
    pool_res_if res_bus ();

    //////////////////////////////
    // stages
    //////////////////////////////

    // row and column tracking
    pool_decode i_pool_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_data  (in_data),
        .win      (win_bus.dec)
    );

    // line buffer and compares
    pool_execute i_pool_execute (
        .clk (clk),
        .win (win_bus.exe),
        .res (res_bus.exe)
    );

    // output register
    pool_result i_pool_result (
        .clk       (clk),
        .rst_n     (rst_n),
        .res       (res_bus.res),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// ==== pool_win_if.sv ====
interface pool_win_if;

    //////////////////////////////
    // tagged pixel from decode
    //////////////////////////////

    // pixel accepted this cycle
    logic                  px_valid;

    // all channels of that pixel
    pool_pkg::chan_vec_t   px_data;

    // its column in the row
    pool_pkg::col_idx_t    col;

    // role inside the 2x2 window
    pool_pkg::pool_phase_e phase;

    // decode side, tags the stream
    modport dec (
        output px_valid,
        output px_data,
        output col,
        output phase
    );

    // execute side, fields only meaningful with px_valid
    modport exe (
        input px_valid,
        input px_data,
        input col,
        input phase
    );

endinterface

// ==== run_sim.sh ====
#!/bin/sh
# build and run the max-pool testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f max_pool.f --top-module tb_pool_top \
    > build.log 2>&1 || { cat build.log; echo "FAIL: build error"; exit 1; }

./obj_dir/Vtb_pool_top > sim.log 2>&1
cat sim.log

# a failing check always prints the fail message
grep -q "Test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Test completed successfully" sim.log && { echo "PASS"; exit 0; }

echo "FAIL: simulation ended without a result"
exit 1

// ==== tb_pool_top.sv ====
`include "pool_defs.svh"

module tb_pool_top;

    import pool_pkg::*;

    localparam int COLS       = `POOL_IMG_COLS;
    localparam int ROWS       = `POOL_IMG_ROWS;
    localparam int CH         = `POOL_CHANNELS;
    localparam int WINS       = (ROWS / 2) * (COLS / 2);
    localparam int NUM_FRAMES = 3;
    localparam int DRAIN_MAX  = 20;

    //////////////////////////////
    // dut signals
    //////////////////////////////

    logic      clk;
    logic      rst_n;
    logic      in_valid;
    chan_vec_t in_data;
    logic      out_valid;
    chan_vec_t out_data;

    pool_top i_pool_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////
    // model state
    //////////////////////////////

    // current frame, as driven
    chan_vec_t   frame_px [ROWS][COLS];
    // expected window maxima in order
    chan_vec_t   exp_q [$];
    int          m_row;
    int          m_col;
    // last accepted pixel closed a window
    logic        br_last;
    // out_valid pulses seen on the DUT output
    int          total_results;
    string       cur_test;
    logic [31:0] lcg_state;

    // linear congruential generator
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic pixel_t max_of_four(input pixel_t a, input pixel_t b,
                                           input pixel_t c, input pixel_t d);
        pixel_t best;
        best = a;
        if (b > best) best = b;
        if (c > best) best = c;
        if (d > best) best = d;
        return best;
    endfunction

    // random pixel; first window of a frame puts channel c's peak at position c
    function automatic chan_vec_t make_pixel(input int row, input int col);
        chan_vec_t   px;
        logic [31:0] r;
        int          pos;
        pos = (row % 2) * 2 + (col % 2);
        for (int c = 0; c < CH; c++) begin
            r = next_rand();
            px[c] = pixel_t'(r[31:8]);
            if (row < 2 && col < 2) begin
                // top bit decides the winner inside the window
                px[c][`POOL_DATA_W-1] = (pos == c % 4);
            end
        end
        return px;
    endfunction

    // junk driven during gaps, must be ignored
    function automatic chan_vec_t noise_pixel();
        chan_vec_t   px;
        logic [31:0] r;
        for (int c = 0; c < CH; c++) begin
            r = next_rand();
            px[c] = pixel_t'(r[31:8]);
        end
        return px;
    endfunction

    // idle cycles before a pixel
    function automatic int gap_len(input int row, input int col);
        logic [31:0] r;
        r = next_rand();
        // frames run back to back
        if (row == 0 && col == 0) return 0;
        // row ends and between left and right of a window
        if (col == 0 || (row % 2 == 1 && col % 2 == 1)) return 1 + int'(r[17:16]);
        if (r[20:18] == 3'd0) return 1 + int'(r[22:21]);
        return 0;
    endfunction

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    // outputs here reflect the previous rising edge
    task automatic check_outputs();
        chan_vec_t exp;
        // tally of results actually delivered
        if (out_valid === 1'b1) begin
            total_results++;
        end
        if (br_last) begin
            exp = exp_q.pop_front();
            assert (out_valid === 1'b1) else report_failure($sformatf(
                "[ERROR] %s out_valid: expected 1, actual %b", cur_test, out_valid));
            for (int c = 0; c < CH; c++) begin
                assert (out_data[c] === exp[c]) else report_failure($sformatf(
                    "[ERROR] %s ch%0d max: expected %h, actual %h",
                    cur_test, c, exp[c], out_data[c]));
            end
        end else begin
            assert (out_valid === 1'b0) else report_failure($sformatf(
                "[ERROR] %s out_valid: expected 0, actual %b", cur_test, out_valid));
            // data must be zero with no result
            assert (out_data === '0) else report_failure($sformatf(
                "[ERROR] %s idle out_data: expected %h, actual %h",
                cur_test, chan_vec_t'(0), out_data));
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic model_accept(input chan_vec_t d);
        chan_vec_t exp;
        frame_px[m_row][m_col] = d;
        // odd row, odd col closes a window
        if (m_row % 2 == 1 && m_col % 2 == 1) begin
            for (int c = 0; c < CH; c++) begin
                exp[c] = max_of_four(frame_px[m_row-1][m_col-1][c],
                                     frame_px[m_row-1][m_col][c],
                                     frame_px[m_row][m_col-1][c], d[c]);
            end
            exp_q.push_back(exp);
            br_last = 1'b1;
        end
        if (m_col == COLS - 1) begin
            m_col = 0;
            m_row = (m_row == ROWS - 1) ? 0 : m_row + 1;
        end else begin
            m_col++;
        end
    endtask

    // one clock: check, then drive on the falling edge
    task automatic tick(input logic v, input chan_vec_t d);
        @(negedge clk);
        check_outputs();
        in_valid = v;
        in_data  = d;
        br_last  = 1'b0;
        if (v) model_accept(d);
    endtask

    task automatic drive_frame(input bit gapped);
        int gaps;
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                gaps = gapped ? gap_len(r, c) : 0;
                for (int g = 0; g < gaps; g++) begin
                    tick(1'b0, noise_pixel());
                end
                tick(1'b1, make_pixel(r, c));
            end
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        int wait_cnt;
        lcg_state     = 32'd51734;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        in_data       = '0;
        br_last       = 1'b0;
        total_results = 0;
        m_row         = 0;
        m_col         = 0;
        cur_test      = "reset";

        // outputs quiet while reset is held
        repeat (8) begin
            @(negedge clk);
            check_outputs();
        end
        rst_n = 1'b1;

        cur_test = "idle_after_reset";
        repeat (4) tick(1'b0, '0);

        cur_test = "frame0_no_gaps";
        drive_frame(1'b0);
        // next frame starts with no idle cycle
        cur_test = "frame1_gaps";
        drive_frame(1'b1);
        cur_test = "frame2_gaps";
        drive_frame(1'b1);

        // last window result still in flight
        cur_test = "drain";
        wait_cnt = 0;
        while (exp_q.size() != 0) begin
            if (wait_cnt == DRAIN_MAX) begin
                report_failure("timeout waiting for the last window result");
            end else begin
                tick(1'b0, '0);
                wait_cnt++;
            end
        end
        repeat (4) tick(1'b0, '0);

        assert (total_results == NUM_FRAMES * WINS) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            report_failure($sformatf(
                "[ERROR] result_count: expected %0d, actual %0d",
                NUM_FRAMES * WINS, total_results));
        end
    end

endmodule
